// ==== project.f ====
+incdir+src
src/mul_pkg.sv
src/mul_req_if.sv
src/mult32x32.sv
src/mult64x64.sv
src/mul_issue_arbiter.sv
src/mul_port.sv
src/mul_top.sv
verification/mul_asserts.sv
verification/mul_tb.sv

// ==== verification/mul_tb.sv ====
/*
  mul_tb
  directed testbench for the shared multiply unit
  drives both peers of mul_top, derives expected products from the
  operands, checks latency, contention, streaming and busy starts
*/
`include "mul_params.svh"

module mul_tb;

  localparam int CLK_HALF        = 20;
  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 64;
  localparam int DONE_LIMIT      = 40;
  localparam int STREAM_ROUNDS   = 8;

  logic              clk = 1'b0;
  logic              rst;
  logic              start0;
  logic              start1;
  mul_pkg::mul_op_e  op0;
  mul_pkg::mul_op_e  op1;
  logic [`MUL_W-1:0] a0;
  logic [`MUL_W-1:0] b0;
  logic [`MUL_W-1:0] a1;
  logic [`MUL_W-1:0] b1;
  logic              busy0;
  logic              busy1;
  logic              done0;
  logic              done1;
  logic [`MUL_W-1:0] result0;
  logic [`MUL_W-1:0] result1;

  integer            seed;
  int                err_cnt = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  // operands for the streaming test, drawn before the two streams fork
  logic [`MUL_W-1:0] st_a  [2][STREAM_ROUNDS];
  logic [`MUL_W-1:0] st_b  [2][STREAM_ROUNDS];
  mul_pkg::mul_op_e  st_op [2][STREAM_ROUNDS];

  mul_top DUT (
    .clk     (clk),
    .rst     (rst),
    .start0  (start0),
    .start1  (start1),
    .op0     (op0),
    .op1     (op1),
    .a0      (a0),
    .b0      (b0),
    .a1      (a1),
    .b1      (b1),
    .busy0   (busy0),
    .busy1   (busy1),
    .done0   (done0),
    .done1   (done1),
    .result0 (result0),
    .result1 (result1)
  );

  always #(CLK_HALF) clk = ~clk;

  // ==============================
  // helpers
  // ==============================

  // reference product from the operands alone, then the half asked for
  function automatic logic [`MUL_W-1:0] expected_half(input logic [`MUL_W-1:0] x,
                                                      input logic [`MUL_W-1:0] y,
                                                      input mul_pkg::mul_op_e op);
    logic [2*`MUL_W-1:0] full;
    full = {{`MUL_W{1'b0}}, x} * {{`MUL_W{1'b0}}, y};
    return (op == mul_pkg::MUL_HI) ? full[2*`MUL_W-1:`MUL_W] : full[`MUL_W-1:0];
  endfunction

  task automatic check(input string name, input logic [`MUL_W-1:0] exp,
                       input logic [`MUL_W-1:0] got);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  // call right after a rising edge, the port samples start on the next one
  task automatic drive_req(input bit p, input mul_pkg::mul_op_e op,
                           input logic [`MUL_W-1:0] x, input logic [`MUL_W-1:0] y);
    if (p) begin
      start1 <= 1'b1;
      op1    <= op;
      a1     <= x;
      b1     <= y;
    end else begin
      start0 <= 1'b1;
      op0    <= op;
      a0     <= x;
      b0     <= y;
    end
  endtask

  // edges counts rising edges from the one that drove start
  // done and result are looked at on the falling edge where they are settled
  task automatic wait_port(input bit p, input int limit, output int edges,
                           output logic [`MUL_W-1:0] res);
    edges = -1;
    res   = 'x;
    for (int n = 1; n <= limit; n++) begin
      @(posedge clk);
      if (n == 1) begin
        if (p) begin
          start1 <= 1'b0;
        end else begin
          start0 <= 1'b0;
        end
      end
      @(negedge clk);
      if ((p ? done1 : done0) === 1'b1) begin
        edges = n;
        res   = p ? result1 : result0;
        break;
      end
    end
    if (edges < 0) begin
      $display("port %0d never signalled done within %0d cycles of its start", p, limit);
      err_cnt++;
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================

  task automatic test_reset_lo();
    int                e0;
    int                edges;
    logic [`MUL_W-1:0] x;
    logic [`MUL_W-1:0] y;
    logic [`MUL_W-1:0] res;
    e0 = err_cnt;
    x  = 64'h0123_4567_89ab_cdef;
    y  = 64'hfedc_ba98_7654_3210;
    @(negedge clk);
    check("busy0", 1'b0, busy0);
    check("busy1", 1'b0, busy1);
    check("done0", 1'b0, done0);
    check("done1", 1'b0, done1);
    @(posedge clk);
    drive_req(1'b0, mul_pkg::MUL_LO, x, y);
    wait_port(1'b0, DONE_LIMIT, edges, res);
    // start sampled one edge after it is driven, done twelve edges later
    check("done0 latency", 13, edges);
    check("result0", expected_half(x, y, mul_pkg::MUL_LO), res);
    end_test(1, "reset state and low half", e0);
  endtask

  task automatic test_hi_corners();
    int                e0;
    int                edges;
    logic [`MUL_W-1:0] ca [5];
    logic [`MUL_W-1:0] cb [5];
    logic [`MUL_W-1:0] res;
    e0    = err_cnt;
    ca[0] = 64'h0;
    cb[0] = 64'hdead_beef_cafe_f00d;
    ca[1] = 64'h1;
    cb[1] = 64'h8000_0000_0000_0001;
    ca[2] = '1;
    cb[2] = '1;
    // low half below high half in a, high below low in b, both middle diffs negative
    ca[3] = 64'hffff_ffff_0000_0001;
    cb[3] = 64'h0000_0002_ffff_fffe;
    // only a's difference negative, so the middle product is subtracted
    ca[4] = 64'hffff_0000_0000_1234;
    cb[4] = 64'h8000_0000_7fff_ffff;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      drive_req(1'b0, mul_pkg::MUL_HI, ca[i], cb[i]);
      wait_port(1'b0, DONE_LIMIT, edges, res);
      if (edges >= 0) begin
        check($sformatf("result0 case %0d", i), expected_half(ca[i], cb[i], mul_pkg::MUL_HI), res);
      end
    end
    end_test(2, "high half with corner operands", e0);
  endtask

  task automatic test_contention();
    int                e0;
    int                t0;
    int                t1;
    logic [`MUL_W-1:0] r0;
    logic [`MUL_W-1:0] r1;
    e0 = err_cnt;
    // a fresh reset puts the round-robin pointer back on port 0
    reset_dut();
    @(posedge clk);
    drive_req(1'b0, mul_pkg::MUL_LO, 64'h1111_2222_3333_4444, 64'h9999_8888_7777_6666);
    drive_req(1'b1, mul_pkg::MUL_HI, 64'hfedc_0000_1234_ffff, 64'h0bad_f00d_0000_0003);
    fork
      wait_port(1'b0, DONE_LIMIT, t0, r0);
      wait_port(1'b1, DONE_LIMIT, t1, r1);
    join
    check("result0", expected_half(64'h1111_2222_3333_4444, 64'h9999_8888_7777_6666,
                                   mul_pkg::MUL_LO), r0);
    check("result1", expected_half(64'hfedc_0000_1234_ffff, 64'h0bad_f00d_0000_0003,
                                   mul_pkg::MUL_HI), r1);
    check("done0 latency", 13, t0);
    check("done1 latency", 14, t1);
    end_test(3, "both ports start together", e0);
  endtask

  // one peer restarting on every done, its own operands per round
  task automatic run_stream(input bit p);
    int                edges;
    logic [`MUL_W-1:0] res;
    for (int i = 0; i < STREAM_ROUNDS; i++) begin
      @(posedge clk);
      drive_req(p, st_op[p][i], st_a[p][i], st_b[p][i]);
      wait_port(p, DONE_LIMIT, edges, res);
      if (edges >= 0) begin
        check($sformatf("result%0d round %0d", p, i),
              expected_half(st_a[p][i], st_b[p][i], st_op[p][i]), res);
      end
    end
  endtask

  task automatic test_streams();
    int     e0;
    integer rnd;
    e0 = err_cnt;
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < STREAM_ROUNDS; i++) begin
        st_a[p][i]  = {$random(seed), $random(seed)};
        st_b[p][i]  = {$random(seed), $random(seed)};
        rnd         = $random(seed);
        st_op[p][i] = rnd[0] ? mul_pkg::MUL_HI : mul_pkg::MUL_LO;
      end
    end
    fork
      run_stream(1'b0);
      run_stream(1'b1);
    join
    end_test(4, "back-to-back random streams", e0);
  endtask

  task automatic test_busy_start();
    int                e0;
    int                edges;
    int                extra;
    logic [`MUL_W-1:0] res;
    e0    = err_cnt;
    extra = 0;
    @(posedge clk);
    drive_req(1'b0, mul_pkg::MUL_LO, 64'h7777_0000_0000_8888, 64'h0000_0005_a5a5_a5a5);
    @(posedge clk);
    start0 <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check("busy0", 1'b1, busy0);
    // second request while the first is still in the pipeline
    @(posedge clk);
    drive_req(1'b0, mul_pkg::MUL_HI, 64'hffff_ffff_ffff_fff0, 64'h1234_5678_9abc_def0);
    wait_port(1'b0, DONE_LIMIT, edges, res);
    if (edges >= 0) begin
      check("result0", expected_half(64'h7777_0000_0000_8888, 64'h0000_0005_a5a5_a5a5,
                                     mul_pkg::MUL_LO), res);
    end
    repeat (20) begin
      @(negedge clk);
      if (done0 === 1'b1) begin
        extra++;
      end
    end
    check("extra done0 pulses", 0, extra);
    check("busy0", 1'b0, busy0);
    end_test(5, "start while busy is ignored", e0);
  endtask

  // ==============================
  // sequence and verdict
  // ==============================

  initial begin
    seed   = 32'h18cc;
    rst    = 1'b1;
    start0 = 1'b0;
    start1 = 1'b0;
    op0    = mul_pkg::MUL_LO;
    op1    = mul_pkg::MUL_LO;
    a0     = '0;
    b0     = '0;
    a1     = '0;
    b1     = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    test_reset_lo();
    test_hi_corners();
    test_contention();
    test_streams();
    test_busy_start();

    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, err_cnt, DUT.u_arb.u_asserts.fail_cnt);
    if (tests_failed == 0 && err_cnt == 0 && DUT.u_arb.u_asserts.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // bound on the whole run, sized from the number of tests
  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== verification/mul_asserts.sv ====
/*
  mul_asserts
  concurrent checks on the issue arbiter, attached with bind
  one grant at a time, grants only to requesters, and every grant
  comes back as rvalid on the same port MUL_LAT cycles later
*/
`include "mul_params.svh"

module mul_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic [`MUL_PORTS-1:0] req,
  input logic [`MUL_PORTS-1:0] gnt,
  input logic                  ret_vld,
  input mul_pkg::port_id_t     ret_tag
);

  // running count of failed assertions
  int fail_cnt = 0;

  // ==============================
  // issue side
  // ==============================

  a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
    else begin
      $error("arbiter granted both ports in the same cycle");
      fail_cnt++;
    end

  a_grant_has_req: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == '0)
    else begin
      $error("arbiter granted a port that was not requesting");
      fail_cnt++;
    end

  // ==============================
  // return side
  // ==============================

  // the tag must bring the product back to the port that was granted
  a_ret0: assert property (@(posedge clk) disable iff (rst)
    gnt[0] |-> ##`MUL_LAT (ret_vld && ret_tag == 1'b0))
    else begin
      $error("port 0 grant not followed by its rvalid after MUL_LAT cycles");
      fail_cnt++;
    end

  a_ret1: assert property (@(posedge clk) disable iff (rst)
    gnt[1] |-> ##`MUL_LAT (ret_vld && ret_tag == 1'b1))
    else begin
      $error("port 1 grant not followed by its rvalid after MUL_LAT cycles");
      fail_cnt++;
    end

  // no return without a matching grant in the past
  // the grant vector is taken from back then, the port from the tag now
  a_ret_had_grant: assert property (@(posedge clk) disable iff (rst)
    ret_vld |-> ($past(gnt, `MUL_LAT) & (`MUL_PORTS'(1) << ret_tag)) != '0)
    else begin
      $error("rvalid raised without a grant MUL_LAT cycles earlier");
      fail_cnt++;
    end

endmodule

bind mul_issue_arbiter mul_asserts u_asserts (
  .clk     (clk),
  .rst     (rst),
  .req     (req_vec),
  .gnt     (gnt_vec),
  .ret_vld (ret_vld),
  .ret_tag (ret_tag)
);

// ==== src/mul_top.sv ====
/*
  mul_top
  shared 64-bit multiply unit serving two peers through one arbiter
  uncontended, done rises on the 12th edge after the edge that samples
  start, which is 13 edges after the edge that drives start high
*/
`include "mul_params.svh"

module mul_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              start0,
  input  logic              start1,
  input  mul_pkg::mul_op_e  op0,
  input  mul_pkg::mul_op_e  op1,
  input  logic [`MUL_W-1:0] a0,
  input  logic [`MUL_W-1:0] b0,
  input  logic [`MUL_W-1:0] a1,
  input  logic [`MUL_W-1:0] b1,
  output logic              busy0,
  output logic              busy1,
  output logic              done0,
  output logic              done1,
  output logic [`MUL_W-1:0] result0,
  output logic [`MUL_W-1:0] result1
);

  // operands from the arbiter and the product back to it
  logic [`MUL_W-1:0] mul_a;
  logic [`MUL_W-1:0] mul_b;
  mul_pkg::prod_u    mul_o;

  mul_req_if bus0 ();
  mul_req_if bus1 ();

  // ==============================
  // peer front ends
  // ==============================

  mul_port u_port0 (
    .clk    (clk),
    .rst    (rst),
    .start  (start0),
    .op     (op0),
    .a      (a0),
    .b      (b0),
    .busy   (busy0),
    .done   (done0),
    .result (result0),
    .bus    (bus0.port)
  );

  mul_port u_port1 (
    .clk    (clk),
    .rst    (rst),
    .start  (start1),
    .op     (op1),
    .a      (a1),
    .b      (b1),
    .busy   (busy1),
    .done   (done1),
    .result (result1),
    .bus    (bus1.port)
  );

  // ==============================
  // shared multiplier
  // ==============================

  mul_issue_arbiter u_arb (
    .clk   (clk),
    .rst   (rst),
    .p0    (bus0.arb),
    .p1    (bus1.arb),
    .mul_a (mul_a),
    .mul_b (mul_b),
    .mul_o (mul_o)
  );

  mult64x64 u_mult (
    .clk (clk),
    .a   (mul_a),
    .b   (mul_b),
    .o   (mul_o)
  );

endmodule

// ==== src/mul_port.sv ====
/*
  mul_port
  front end for one peer, takes a start strobe with operands and op,
  holds the request until issued, then returns the selected product
  half with a done pulse, starts arriving while busy are dropped
*/
`include "mul_params.svh"

module mul_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  mul_pkg::mul_op_e  op,
  input  logic [`MUL_W-1:0] a,
  input  logic [`MUL_W-1:0] b,
  output logic              busy,
  output logic              done,
  output logic [`MUL_W-1:0] result,
  mul_req_if.port           bus
);

  logic              req_q;
  logic              accept;
  mul_pkg::mul_op_e  op_q;
  logic [`MUL_W-1:0] a_q;
  logic [`MUL_W-1:0] b_q;

  assign accept = start && !busy;

  // busy covers both the wait for issue and the trip through the pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      req_q <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy  <= 1'b1;
        req_q <= 1'b1;
      end else begin
        if (bus.grant) begin
          req_q <= 1'b0;
        end
        if (bus.rvalid && busy) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // request payload, stays put until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= op;
      a_q  <= a;
      b_q  <= b;
    end
  end

  // pick the half asked for when the product comes back
  always_ff @(posedge clk) begin
    if (bus.rvalid) begin
      result <= (op_q == mul_pkg::MUL_HI) ? bus.result.halves.hi : bus.result.halves.lo;
    end
  end

  assign bus.req = req_q;
  assign bus.a   = a_q;
  assign bus.b   = b_q;

endmodule

// ==== src/mul_issue_arbiter.sv ====
/*
  mul_issue_arbiter
  round-robin issue of peer requests onto the shared multiplier
  a valid bit and the peer tag follow each operation down a delay line
  as long as the multiplier, and steer the product back to its owner
*/
`include "mul_params.svh"

module mul_issue_arbiter (
  input  logic              clk,
  input  logic              rst,
  mul_req_if.arb            p0,
  mul_req_if.arb            p1,
  output logic [`MUL_W-1:0] mul_a,
  output logic [`MUL_W-1:0] mul_b,
  input  mul_pkg::prod_u    mul_o
);

  logic [`MUL_PORTS-1:0] req_vec;
  logic [`MUL_PORTS-1:0] gnt_vec;
  logic                  gnt_any;
  mul_pkg::port_id_t     gnt_id;
  // peer that wins when both are asking
  mul_pkg::port_id_t     prio;

  // issue history, entry MUL_LAT-1 lines up with the multiplier output
  logic [`MUL_LAT-1:0]   vld_pipe;
  mul_pkg::port_id_t     tag_pipe [0:`MUL_LAT-1];
  logic                  ret_vld;
  mul_pkg::port_id_t     ret_tag;

  assign req_vec = {p1.req, p0.req};

  // ==============================
  // selection
  // ==============================

  // with two peers the other one is simply the complement of prio
  always_comb begin
    gnt_any = |req_vec;
    if (req_vec[prio]) begin
      gnt_id = prio;
    end else begin
      gnt_id = ~prio;
    end
    gnt_vec = '0;
    if (gnt_any) begin
      gnt_vec[gnt_id] = 1'b1;
    end
  end

  // the peer just served drops to the back
  always_ff @(posedge clk) begin
    if (rst) begin
      prio <= '0;
    end else if (gnt_any) begin
      prio <= ~gnt_id;
    end
  end

  assign p0.grant = gnt_vec[0];
  assign p1.grant = gnt_vec[1];

  // the multiplier samples whatever is here at the end of the cycle
  assign mul_a = gnt_id ? p1.a : p0.a;
  assign mul_b = gnt_id ? p1.b : p0.b;

  // ==============================
  // return path
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`MUL_LAT-2:0], gnt_any};
    end
  end

  // tag is only looked at when its valid bit is set
  always_ff @(posedge clk) begin
    tag_pipe[0] <= gnt_id;
    for (int i = 1; i < `MUL_LAT; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
    end
  end

  assign ret_vld = vld_pipe[`MUL_LAT-1];
  assign ret_tag = tag_pipe[`MUL_LAT-1];

  assign p0.rvalid = ret_vld && (ret_tag == mul_pkg::port_id_t'(0));
  assign p1.rvalid = ret_vld && (ret_tag == mul_pkg::port_id_t'(1));

  // product bus is shared, rvalid says whose it is
  assign p0.result = mul_o;
  assign p1.result = mul_o;

endmodule

// ==== src/mult64x64.sv ====
/*
  mult64x64
  unsigned 64x64 Karatsuba multiplier giving the full 128-bit product
  three 32x32 products, hi*hi, lo*lo and |lo-hi|*|hi-lo|, recombined
  with the middle term sign restored, eleven clocks, fully pipelined
*/
`include "mul_params.svh"

module mult64x64 (
  input  logic              clk,
  input  logic [`MUL_W-1:0] a,
  input  logic [`MUL_W-1:0] b,
  output mul_pkg::prod_u    o
);

  localparam int HW = `MUL_W / 2;
  // registers on the hi*hi and lo*lo paths after their multiplier
  // three to line up with the negate stage, one more for the final add
  localparam int Z_DLY = 4;

  // 33-bit differences, bit HW is the borrow and so the sign
  logic [HW:0]            a_diff;
  logic [HW:0]            b_diff;
  logic [HW-1:0]          a_abs;
  logic [HW-1:0]          b_abs;
  // sign of the middle product, delayed to meet its magnitude
  logic [`MUL_HALF_LAT:0] sgn_pipe;

  logic [`MUL_W-1:0]      z2;
  logic [`MUL_W-1:0]      z0;
  logic [`MUL_W-1:0]      p3;
  // middle product with sign applied, one extra bit so that
  // a zero magnitude with a set sign still comes out as zero
  logic [`MUL_W:0]        p4;
  logic [`MUL_W-1:0]      z2_dly [0:Z_DLY-1];
  logic [`MUL_W-1:0]      z0_dly [0:Z_DLY-1];
  // x1*y0 + x0*y1, which can reach 2^65 - 1
  logic [`MUL_W:0]        z1;

  // ==============================
  // middle term operands
  // ==============================

  // x0 - x1 and y1 - y0, the order Karatsuba needs for a plus sign
  always_ff @(posedge clk) begin
    a_diff <= {1'b0, a[HW-1:0]} - {1'b0, a[`MUL_W-1:HW]};
    b_diff <= {1'b0, b[`MUL_W-1:HW]} - {1'b0, b[HW-1:0]};
  end

  always_ff @(posedge clk) begin
    a_abs <= a_diff[HW] ? HW'(-a_diff) : a_diff[HW-1:0];
    b_abs <= b_diff[HW] ? HW'(-b_diff) : b_diff[HW-1:0];
  end

  // product is negative when exactly one difference is
  always_ff @(posedge clk) begin
    sgn_pipe[0] <= a_diff[HW] ^ b_diff[HW];
    for (int i = 1; i <= `MUL_HALF_LAT; i++) begin
      sgn_pipe[i] <= sgn_pipe[i-1];
    end
  end

  // ==============================
  // partial products
  // ==============================

  // x1 * y1
  mult32x32 u_hi (
    .clk (clk),
    .a   (a[`MUL_W-1:HW]),
    .b   (b[`MUL_W-1:HW]),
    .o   (z2)
  );

  // x0 * y0
  mult32x32 u_lo (
    .clk (clk),
    .a   (a[HW-1:0]),
    .b   (b[HW-1:0]),
    .o   (z0)
  );

  // |x0 - x1| * |y1 - y0|, starts two clocks behind the others
  mult32x32 u_mid (
    .clk (clk),
    .a   (a_abs),
    .b   (b_abs),
    .o   (p3)
  );

  always_ff @(posedge clk) begin
    p4 <= sgn_pipe[`MUL_HALF_LAT] ? -{1'b0, p3} : {1'b0, p3};
  end

  // hold the outer products while the middle path catches up
  always_ff @(posedge clk) begin
    z2_dly[0] <= z2;
    z0_dly[0] <= z0;
    for (int i = 1; i < Z_DLY; i++) begin
      z2_dly[i] <= z2_dly[i-1];
      z0_dly[i] <= z0_dly[i-1];
    end
  end

  // ==============================
  // recombination
  // ==============================

  // modulo 2^65 the signed middle product plus z2 and z0 is exact
  always_ff @(posedge clk) begin
    z1 <= p4 + {1'b0, z2_dly[Z_DLY-2]} + {1'b0, z0_dly[Z_DLY-2]};
  end

  // z2*2^64 + z0 sit side by side, z1 lands at bit 32
  always_ff @(posedge clk) begin
    o.full <= {z2_dly[Z_DLY-1], z0_dly[Z_DLY-1]} + {z1, {HW{1'b0}}};
  end

endmodule

// ==== src/mult32x32.sv ====
/*
  mult32x32
  pipelined unsigned 32x32 multiplier, MUL_HALF_LAT clocks deep
  the multiply is written as one operator and the trailing registers
  are left for the tools to retime into the partial-product tree
*/
`include "mul_params.svh"

module mult32x32 (
  input  logic        clk,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [63:0] o
);

  // the operand registers are the first pipeline stage
  logic [31:0] a_q;
  logic [31:0] b_q;

  // remaining stages hold the product, last entry drives the output
  logic [63:0] prod_pipe [0:`MUL_HALF_LAT-2];

  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
  end

  // product leaves the operand stage and walks down the chain
  // so the whole path is MUL_HALF_LAT registers long
  always_ff @(posedge clk) begin
    prod_pipe[0] <= a_q * b_q;
    for (int i = 1; i < `MUL_HALF_LAT - 1; i++) begin
      prod_pipe[i] <= prod_pipe[i-1];
    end
  end

  assign o = prod_pipe[`MUL_HALF_LAT-2];

endmodule

// ==== src/mul_req_if.sv ====
/*
  mul_req_if
  request and return path between one peer port and the issue arbiter
  req is a level held until grant, grant and rvalid are single-cycle pulses
  rvalid comes MUL_LAT cycles after the grant, with the full product
*/
`include "mul_params.svh"

interface mul_req_if;

  // port holds this high while it has an operation waiting for issue
  logic                req;
  // operands, stable for as long as req is high
  logic [`MUL_W-1:0]   a;
  logic [`MUL_W-1:0]   b;

  // operands enter the multiplier at the end of the grant cycle
  logic                grant;
  // marks the cycle in which result carries this port's product
  logic                rvalid;
  // shared product bus, only meaningful together with rvalid
  mul_pkg::prod_u      result;

  // ==============================
  // views
  // ==============================

  modport port (
    output req,
    output a,
    output b,
    input  grant,
    input  rvalid,
    input  result
  );

  modport arb (
    input  req,
    input  a,
    input  b,
    output grant,
    output rvalid,
    output result
  );

endinterface

// ==== src/mul_pkg.sv ====
/*
  mul_pkg
  types shared by the peer ports, the issue arbiter and the multiplier
*/
`include "mul_params.svh"

package mul_pkg;

  // selects which half of the 128-bit product a peer gets back
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HI = 1'b1
  } mul_op_e;

  // the product seen as two result words, hi on top
  typedef struct packed {
    logic [`MUL_W-1:0] hi;
    logic [`MUL_W-1:0] lo;
  } prod_halves_t;

  // the multiplier writes the full word
  // the ports only ever read one of the halves
  typedef union packed {
    logic [2*`MUL_W-1:0] full;
    prod_halves_t        halves;
  } prod_u;

  // index of a peer, also used as the tag that rides alongside
  // an operation through the pipeline
  typedef logic [$clog2(`MUL_PORTS)-1:0] port_id_t;

endpackage

// ==== src/mul_params.svh ====
/*
  shared multiply parameters
  operand width, pipeline depths and the number of requesting peers
*/
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// width of each unsigned operand and of each result half
`define MUL_W 64

// ==============================
// pipeline depths
// ==============================

// total clocks through the Karatsuba multiplier
`define MUL_LAT 11

// clocks through one 32x32 partial multiplier
`define MUL_HALF_LAT 6

// ==============================
// arbitration
// ==============================

// number of peers sharing the multiplier
`define MUL_PORTS 2

`endif
